/* bench/cdr_debug_tb.sv */
`include "dbg_macros.svh"

module cdr_debug_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS = 8;
	localparam int CFG_W = $bits(dbg_pkg::dbg_cfg_t);
	// Each tck period is 6 clk high and 6 clk low
	localparam int TCK_CLKS = 12;
	localparam int N_SCANS = 200;
	localparam int MAX_SCAN_PULSES = 37;
	localparam int STIM_CLKS = 1000;
	localparam int TIMEOUT_NS = (N_SCANS * MAX_SCAN_PULSES * TCK_CLKS + STIM_CLKS) * CLK_NS;

	logic clk;
	logic rst_n_i;
	logic tck_i, tms_i, tdi_i, trst_n_i;
	logic tdo_o;
	logic [`DBG_PD_W-1:0] pd_err_i;
	logic pd_valid_i;
	logic [`DBG_PI_W-1:0] pi_ctl_o;

	int checks = 0;
	int errors = 0;
	logic pi_hold = 1'b1;
	dbg_pkg::dbg_cfg_t cur_cfg;

	// Reference state
	logic [`DBG_PH_W-1:0] model_phase;
	logic [`DBG_FR_W-1:0] model_freq;
	logic [`DBG_PI_W-1:0] model_pi;
	logic [`DBG_ADDR_W-1:0] model_ptr;
	logic [`DBG_PD_W-1:0] model_mem [2**`DBG_ADDR_W];

	cdr_debug_top dut (.clk(clk), .rst_n_i(rst_n_i), .tck_i(tck_i), .tms_i(tms_i),
		.tdi_i(tdi_i), .trst_n_i(trst_n_i), .tdo_o(tdo_o), .pd_err_i(pd_err_i),
		.pd_valid_i(pd_valid_i), .pi_ctl_o(pi_ctl_o));

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s = %h, expected %h", $time, name, actual,
				expected);
		end
	endtask

	// Integral path, then proportional path on top of the new frequency
	function automatic logic [31:0] loop_step(input logic [`DBG_PH_W-1:0] phase,
		input logic [`DBG_FR_W-1:0] freq, input logic [`DBG_PD_W-1:0] pd,
		input logic [`DBG_K_W-1:0] kp, input logic [`DBG_K_W-1:0] ki);
		int pd_val;
		int freq_new;
		int phase_new;
		pd_val = $signed(pd);
		freq_new = int'(freq) + (pd_val >>> ki);
		phase_new = int'(phase) + freq_new + (pd_val >>> kp);
		return {`DBG_PH_W'(phase_new), `DBG_FR_W'(freq_new)};
	endfunction

	function automatic logic [`DBG_PI_W-1:0] pi_code(input dbg_pkg::dbg_cfg_t cfg,
		input logic [`DBG_PH_W-1:0] phase);
		if (cfg.en_ext_pi_ctl)
			return cfg.ext_pi_ctl;
		return phase[`DBG_PH_W-1 -: `DBG_PI_W];
	endfunction

	always @(posedge clk) begin
		logic [31:0] step;
		step = loop_step(model_phase, model_freq, pd_err_i, cur_cfg.kp, cur_cfg.ki);
		if (!rst_n_i || !cur_cfg.int_rstb) begin
			model_phase <= '0;
			model_freq <= '0;
			model_ptr <= '0;
		end else if (pd_valid_i) begin
			model_phase <= step[31:16];
			model_freq <= step[15:0];
			if (cur_cfg.en_capture) begin
				model_mem[model_ptr] <= pd_err_i;
				model_ptr <= model_ptr + 1'b1;
			end
		end
		model_pi <= pi_code(cur_cfg, model_phase);
	end

	// Interpolator code is compared every cycle outside configuration writes
	always @(negedge clk) begin
		if (!pi_hold)
			check_value("pi_ctl_o", pi_ctl_o, model_pi);
	end

	// tdo is sampled late in the low phase, just before the rise
	task automatic tck_pulse(input logic tms, input logic tdi, output logic tdo);
		tms_i = tms;
		tdi_i = tdi;
		repeat (TCK_CLKS / 2) @(posedge clk);
		#1;
		tdo = tdo_o;
		tck_i = 1'b1;
		repeat (TCK_CLKS / 2) @(posedge clk);
		#1;
		tck_i = 1'b0;
	endtask

	task automatic ir_scan(input logic [`DBG_IR_W-1:0] code,
		output logic [`DBG_IR_W-1:0] dout);
		logic bit_out;
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		for (int i = 0; i < `DBG_IR_W; i++) begin
			tck_pulse(i == `DBG_IR_W - 1, code[i], bit_out);
			dout[i] = bit_out;
		end
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
	endtask

	// Starts and ends in Run-Test/Idle
	task automatic dr_scan(input logic [31:0] din, input int len, output logic [31:0] dout);
		logic bit_out;
		dout = '0;
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		for (int i = 0; i < len; i++) begin
			tck_pulse(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
	endtask

	task automatic write_config(input dbg_pkg::dbg_cfg_t cfg_new,
		output dbg_pkg::dbg_cfg_t cfg_old);
		logic [`DBG_IR_W-1:0] ir_bits;
		logic [31:0] dout;
		pi_hold = 1'b1;
		ir_scan(jtag_pkg::CONFIG, ir_bits);
		dr_scan(32'(cfg_new), CFG_W, dout);
		cfg_old = dout[CFG_W-1:0];
		cur_cfg = cfg_new;
		repeat (2) @(posedge clk);
		#1;
		pi_hold = 1'b0;
	endtask

	task automatic apply_samples(input int count);
		int gap;
		for (int n = 0; n < count; n++) begin
			pd_err_i = `DBG_PD_W'($urandom());
			pd_valid_i = 1'b1;
			gap = $urandom_range(0, 3);
			@(posedge clk);
			#1;
			pd_valid_i = 1'b0;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	initial begin
		logic [31:0] dout;
		logic [31:0] din;
		logic [`DBG_IR_W-1:0] ir_bits;
		logic bit_out;
		dbg_pkg::dbg_cfg_t cfg_a;
		dbg_pkg::dbg_cfg_t cfg_b;
		dbg_pkg::dbg_cfg_t cfg_old;
		void'($urandom(2959));
		rst_n_i = 1'b0;
		tck_i = 1'b0;
		tms_i = 1'b0;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		pd_err_i = '0;
		pd_valid_i = 1'b0;
		cur_cfg = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		pi_hold = 1'b0;
		check_value("tdo_o", tdo_o, 0);

		// IDCODE after reset, after five tms-high rises and after trst_n
		tck_pulse(1'b0, 1'b0, bit_out);
		dr_scan(0, 32, dout);
		check_value("idcode", dout, `DBG_IDCODE);
		ir_scan(jtag_pkg::STATUS, ir_bits);
		repeat (5) tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		dr_scan(0, 32, dout);
		check_value("idcode", dout, `DBG_IDCODE);
		ir_scan(jtag_pkg::CONFIG, ir_bits);
		trst_n_i = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		trst_n_i = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		tck_pulse(1'b0, 1'b0, bit_out);
		dr_scan(0, 32, dout);
		check_value("idcode", dout, `DBG_IDCODE);

		// CONFIG readback and BYPASS
		cfg_a = CFG_W'($urandom());
		write_config(cfg_a, cfg_old);
		check_value("config", cfg_old, 0);
		cfg_b = '0;
		cfg_b.en_ext_pi_ctl = 1'b1;
		cfg_b.ext_pi_ctl = `DBG_PI_W'($urandom());
		write_config(cfg_b, cfg_old);
		check_value("config", cfg_old, cfg_a);
		check_value("pi_ctl_o", pi_ctl_o, cfg_b.ext_pi_ctl);
		ir_scan(4'h0, ir_bits);
		check_value("ir_capture", ir_bits[1:0], 2'b01);
		din = 8'($urandom());
		dr_scan(din, 8, dout);
		check_value("bypass", dout, {24'h0, din[6:0], 1'b0});

		// Loop tracking with capture
		cfg_a = '0;
		cfg_a.int_rstb = 1'b1;
		cfg_a.kp = $urandom_range(0, 7);
		cfg_a.ki = $urandom_range(0, 7);
		cfg_a.ext_pi_ctl = `DBG_PI_W'($urandom());
		cfg_a.en_capture = 1'b1;
		write_config(cfg_a, cfg_old);
		check_value("config", cfg_old, cfg_b);
		apply_samples(40);
		ir_scan(jtag_pkg::STATUS, ir_bits);
		dr_scan(0, 32, dout);
		check_value("status", dout, {model_phase, model_freq});
		check_value("pi_ctl_o", pi_ctl_o, model_phase[`DBG_PH_W-1 -: `DBG_PI_W]);

		// Write pointer and stored samples
		ir_scan(jtag_pkg::SRAM_ADDR, ir_bits);
		dr_scan(0, `DBG_ADDR_W, dout);
		check_value("sram_addr", dout, 40 % (2**`DBG_ADDR_W));
		for (int a = 0; a < 40; a++) begin
			ir_scan(jtag_pkg::SRAM_ADDR, ir_bits);
			dr_scan(a, `DBG_ADDR_W, dout);
			check_value("sram_addr", dout, model_ptr);
			ir_scan(jtag_pkg::SRAM_DATA, ir_bits);
			dr_scan(0, `DBG_PD_W, dout);
			check_value("sram_data", dout, model_mem[a]);
		end

		// Cores held in reset ignore samples
		cfg_a.int_rstb = 1'b0;
		write_config(cfg_a, cfg_old);
		ir_scan(jtag_pkg::STATUS, ir_bits);
		dr_scan(0, 32, dout);
		check_value("status", dout, {model_phase, model_freq});
		apply_samples(20);
		dr_scan(0, 32, dout);
		check_value("status", dout, {model_phase, model_freq});
		ir_scan(jtag_pkg::SRAM_ADDR, ir_bits);
		dr_scan(0, `DBG_ADDR_W, dout);
		check_value("sram_addr", dout, model_ptr);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the scan sequence did not complete", TIMEOUT_NS);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Checks failed");
		$finish;
	end
endmodule

/* build.f */
+incdir+include
hw/jtag_pkg.sv
hw/dbg_pkg.sv
hw/dbg_intf.sv
hw/jtag_tap.sv
hw/jtag_regs.sv
hw/jtag.sv
hw/cdr_loop.sv
hw/capture_sram.sv
hw/cdr_debug_top.sv
bench/cdr_debug_tb.sv

/* hw/capture_sram.sv */
`include "dbg_macros.svh"

`default_nettype none

module capture_sram (
	input wire logic clk,
	input wire logic [`DBG_PD_W-1:0] pd_err_i,
	input wire logic pd_valid_i,
	sram_debug_intf.sram dbg
);
	logic [`DBG_PD_W-1:0] mem [2**`DBG_ADDR_W];
	logic wr_en;

	assign wr_en = dbg.rstb & dbg.en_capture & pd_valid_i;

	// Write pointer wraps at the memory depth
	always_ff @(posedge clk) begin
		if (!dbg.rstb)
			dbg.addr <= '0;
		else if (wr_en)
			dbg.addr <= dbg.addr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[dbg.addr] <= pd_err_i;
		dbg.out_data <= mem[dbg.in_addr];
	end
endmodule

`default_nettype wire

/* hw/cdr_debug_top.sv */
`include "dbg_macros.svh"

`default_nettype none

module cdr_debug_top (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	input wire logic [`DBG_PD_W-1:0] pd_err_i,
	input wire logic pd_valid_i,
	output logic [`DBG_PI_W-1:0] pi_ctl_o
);
	logic tck_rise, tck_fall;
	logic tms, tdi, trst_n;
	logic capture_dr, shift_dr, update_dr;
	logic dr_tdo;
	jtag_pkg::jtag_instr_t instr;
	dbg_pkg::dbg_cfg_t cfg;
	dbg_pkg::dbg_sts_t sts;
	logic [`DBG_ADDR_W-1:0] sram_addr_sel;
	logic [`DBG_ADDR_W-1:0] sram_addr;
	logic [`DBG_PD_W-1:0] sram_data;

	cdr_debug_intf cdbg_intf_i ();
	sram_debug_intf sdbg_intf_i ();

	jtag jtag_i (.clk(clk), .rst_n_i(rst_n_i), .tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i),
		.trst_n_i(trst_n_i), .cfg_i(cfg), .sram_addr_sel_i(sram_addr_sel),
		.tck_rise_o(tck_rise), .tck_fall_o(tck_fall), .tms_o(tms), .tdi_o(tdi),
		.trst_n_o(trst_n), .sts_o(sts), .sram_addr_o(sram_addr), .sram_data_o(sram_data),
		.cdbg(cdbg_intf_i), .sdbg(sdbg_intf_i));

	jtag_tap tap_i (.clk(clk), .rst_n_i(rst_n_i), .tck_rise_i(tck_rise),
		.tck_fall_i(tck_fall), .tms_i(tms), .tdi_i(tdi), .trst_n_i(trst_n),
		.dr_tdo_i(dr_tdo), .capture_dr_o(capture_dr), .shift_dr_o(shift_dr),
		.update_dr_o(update_dr), .instr_o(instr), .tdo_o(tdo_o));

	jtag_regs regs_i (.clk(clk), .rst_n_i(rst_n_i), .tck_rise_i(tck_rise), .tdi_i(tdi),
		.capture_dr_i(capture_dr), .shift_dr_i(shift_dr), .update_dr_i(update_dr),
		.instr_i(instr), .sts_i(sts), .sram_addr_i(sram_addr), .sram_data_i(sram_data),
		.cfg_o(cfg), .sram_addr_sel_o(sram_addr_sel), .dr_tdo_o(dr_tdo));

	cdr_loop cdr_i (.clk(clk), .pd_err_i(pd_err_i), .pd_valid_i(pd_valid_i),
		.dbg(cdbg_intf_i), .pi_ctl_o(pi_ctl_o));

	capture_sram sram_i (.clk(clk), .pd_err_i(pd_err_i), .pd_valid_i(pd_valid_i),
		.dbg(sdbg_intf_i));
endmodule

`default_nettype wire

/* hw/cdr_loop.sv */
`include "dbg_macros.svh"

`default_nettype none

module cdr_loop (
	input wire logic clk,
	input wire logic [`DBG_PD_W-1:0] pd_err_i,
	input wire logic pd_valid_i,
	cdr_debug_intf.cdr dbg,
	output logic [`DBG_PI_W-1:0] pi_ctl_o
);
	logic signed [`DBG_FR_W-1:0] pd_fr;
	logic signed [`DBG_PH_W-1:0] pd_ph;
	logic signed [`DBG_FR_W-1:0] fr_step;
	logic signed [`DBG_PH_W-1:0] ph_step;
	logic [`DBG_FR_W-1:0] freq_nxt;
	logic [`DBG_PH_W-1:0] phase_nxt;

	// Sign extend before the arithmetic shifts
	assign pd_fr = {{(`DBG_FR_W-`DBG_PD_W){pd_err_i[`DBG_PD_W-1]}}, pd_err_i};
	assign pd_ph = {{(`DBG_PH_W-`DBG_PD_W){pd_err_i[`DBG_PD_W-1]}}, pd_err_i};
	assign fr_step = pd_fr >>> dbg.ki;
	assign ph_step = pd_ph >>> dbg.kp;

	// Integral path first, proportional path adds on top of it
	assign freq_nxt = dbg.freq_est + fr_step;
	assign phase_nxt = dbg.phase_est + `DBG_PH_W'(freq_nxt) + ph_step;

	always_ff @(posedge clk) begin
		if (!dbg.rstb) begin
			dbg.freq_est <= '0;
			dbg.phase_est <= '0;
		end else if (pd_valid_i) begin
			dbg.freq_est <= freq_nxt;
			dbg.phase_est <= phase_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (dbg.en_ext_pi_ctl)
			pi_ctl_o <= dbg.ext_pi_ctl;
		else
			pi_ctl_o <= dbg.phase_est[`DBG_PH_W-1 -: `DBG_PI_W];
	end
endmodule

`default_nettype wire

/* hw/dbg_intf.sv */
`include "dbg_macros.svh"

`default_nettype none

interface cdr_debug_intf;
	logic                  rstb;
	logic [`DBG_K_W-1:0]   kp;
	logic [`DBG_K_W-1:0]   ki;
	logic                  en_ext_pi_ctl;
	logic [`DBG_PI_W-1:0]  ext_pi_ctl;
	logic [`DBG_PH_W-1:0]  phase_est;
	logic [`DBG_FR_W-1:0]  freq_est;

	modport jtag (output rstb, kp, ki, en_ext_pi_ctl, ext_pi_ctl,
		input phase_est, freq_est);
	modport cdr (input rstb, kp, ki, en_ext_pi_ctl, ext_pi_ctl,
		output phase_est, freq_est);
endinterface

interface sram_debug_intf;
	logic                   rstb;
	logic                   en_capture;
	// Read address from the scan chain
	logic [`DBG_ADDR_W-1:0] in_addr;
	// Write pointer
	logic [`DBG_ADDR_W-1:0] addr;
	logic [`DBG_PD_W-1:0]   out_data;

	modport jtag (output rstb, en_capture, in_addr, input addr, out_data);
	modport sram (input rstb, en_capture, in_addr, output addr, out_data);
endinterface

`default_nettype wire

/* hw/dbg_pkg.sv */
`include "dbg_macros.svh"

package dbg_pkg;

	// First member is the MSB, so en_capture is shifted in and out first
	typedef struct packed {
		// Releases both cores from reset
		logic                  int_rstb;
		logic [`DBG_K_W-1:0]   kp;
		logic [`DBG_K_W-1:0]   ki;
		logic                  en_ext_pi_ctl;
		logic [`DBG_PI_W-1:0]  ext_pi_ctl;
		logic                  en_capture;
	} dbg_cfg_t;

	// Raw accumulator values, two's complement
	typedef struct packed {
		logic [`DBG_PH_W-1:0]  phase_est;
		logic [`DBG_FR_W-1:0]  freq_est;
	} dbg_sts_t;

endpackage

/* hw/jtag.sv */
`include "dbg_macros.svh"

`default_nettype none

module jtag (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	input wire dbg_pkg::dbg_cfg_t cfg_i,
	input wire logic [`DBG_ADDR_W-1:0] sram_addr_sel_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_n_o,
	output dbg_pkg::dbg_sts_t sts_o,
	output logic [`DBG_ADDR_W-1:0] sram_addr_o,
	output logic [`DBG_PD_W-1:0] sram_data_o,
	cdr_debug_intf.jtag cdbg,
	sram_debug_intf.jtag sdbg
);
	// Two sync stages, third tck stage for edge detect
	logic [2:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_sync;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			tck_sync <= '0;
			tms_sync <= '0;
			tdi_sync <= '0;
			trst_sync <= '0;
		end else begin
			tck_sync <= {tck_sync[1:0], tck_i};
			tms_sync <= {tms_sync[0], tms_i};
			tdi_sync <= {tdi_sync[0], tdi_i};
			trst_sync <= {trst_sync[0], trst_n_i};
		end
	end

	assign tck_rise_o = tck_sync[1] & ~tck_sync[2];
	assign tck_fall_o = ~tck_sync[1] & tck_sync[2];
	assign tms_o = tms_sync[1];
	assign tdi_o = tdi_sync[1];
	assign trst_n_o = trst_sync[1];

	// CDR loop
	assign cdbg.rstb = rst_n_i & cfg_i.int_rstb;
	assign cdbg.kp = cfg_i.kp;
	assign cdbg.ki = cfg_i.ki;
	assign cdbg.en_ext_pi_ctl = cfg_i.en_ext_pi_ctl;
	assign cdbg.ext_pi_ctl = cfg_i.ext_pi_ctl;
	assign sts_o.phase_est = cdbg.phase_est;
	assign sts_o.freq_est = cdbg.freq_est;

	// Capture memory
	assign sdbg.rstb = rst_n_i & cfg_i.int_rstb;
	assign sdbg.en_capture = cfg_i.en_capture;
	assign sdbg.in_addr = sram_addr_sel_i;
	assign sram_addr_o = sdbg.addr;
	assign sram_data_o = sdbg.out_data;
endmodule

`default_nettype wire

/* hw/jtag_pkg.sv */
`include "dbg_macros.svh"

package jtag_pkg;

	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR_SCAN,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR_SCAN,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

	// Codes not listed here decode to BYPASS
	typedef enum logic [`DBG_IR_W-1:0] {
		IDCODE    = `DBG_IR_W'h1,
		CONFIG    = `DBG_IR_W'h2,
		STATUS    = `DBG_IR_W'h3,
		SRAM_ADDR = `DBG_IR_W'h4,
		SRAM_DATA = `DBG_IR_W'h5,
		BYPASS    = `DBG_IR_W'hf
	} jtag_instr_t;

endpackage

/* hw/jtag_regs.sv */
`include "dbg_macros.svh"

`default_nettype none

module jtag_regs (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_rise_i,
	input wire logic tdi_i,
	input wire logic capture_dr_i,
	input wire logic shift_dr_i,
	input wire logic update_dr_i,
	input wire jtag_pkg::jtag_instr_t instr_i,
	input wire dbg_pkg::dbg_sts_t sts_i,
	input wire logic [`DBG_ADDR_W-1:0] sram_addr_i,
	input wire logic [`DBG_PD_W-1:0] sram_data_i,
	output dbg_pkg::dbg_cfg_t cfg_o,
	output logic [`DBG_ADDR_W-1:0] sram_addr_sel_o,
	output logic dr_tdo_o
);
	// IDCODE and STATUS are the widest registers
	localparam int DR_W = 32;
	localparam int MSB_W = $clog2(DR_W);
	localparam int CFG_W = $bits(dbg_pkg::dbg_cfg_t);

	logic [DR_W-1:0] dr_sr;
	logic [MSB_W-1:0] dr_msb;

	// TDI enters at the top bit of the selected register
	always_comb begin
		case (instr_i)
			jtag_pkg::IDCODE:    dr_msb = MSB_W'(DR_W - 1);
			jtag_pkg::CONFIG:    dr_msb = MSB_W'(CFG_W - 1);
			jtag_pkg::STATUS:    dr_msb = MSB_W'($bits(dbg_pkg::dbg_sts_t) - 1);
			jtag_pkg::SRAM_ADDR: dr_msb = MSB_W'(`DBG_ADDR_W - 1);
			jtag_pkg::SRAM_DATA: dr_msb = MSB_W'(`DBG_PD_W - 1);
			default:             dr_msb = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (tck_rise_i && capture_dr_i) begin
			case (instr_i)
				jtag_pkg::IDCODE:    dr_sr <= `DBG_IDCODE;
				jtag_pkg::CONFIG:    dr_sr <= DR_W'(cfg_o);
				jtag_pkg::STATUS:    dr_sr <= DR_W'(sts_i);
				jtag_pkg::SRAM_ADDR: dr_sr <= DR_W'(sram_addr_i);
				jtag_pkg::SRAM_DATA: dr_sr <= DR_W'(sram_data_i);
				default:             dr_sr <= '0;
			endcase
		end else if (tck_rise_i && shift_dr_i) begin
			dr_sr <= {1'b0, dr_sr[DR_W-1:1]};
			dr_sr[dr_msb] <= tdi_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cfg_o <= '0;
			sram_addr_sel_o <= '0;
		end else if (tck_rise_i && update_dr_i) begin
			if (instr_i == jtag_pkg::CONFIG)
				cfg_o <= dbg_pkg::dbg_cfg_t'(dr_sr[CFG_W-1:0]);
			else if (instr_i == jtag_pkg::SRAM_ADDR)
				sram_addr_sel_o <= dr_sr[`DBG_ADDR_W-1:0];
		end
	end

	assign dr_tdo_o = dr_sr[0];
endmodule

`default_nettype wire

/* hw/jtag_tap.sv */
`include "dbg_macros.svh"

`default_nettype none

module jtag_tap (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_rise_i,
	input wire logic tck_fall_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	input wire logic dr_tdo_i,
	output logic capture_dr_o,
	output logic shift_dr_o,
	output logic update_dr_o,
	output jtag_pkg::jtag_instr_t instr_o,
	output logic tdo_o
);
	jtag_pkg::tap_state_t state, state_nxt;
	logic [`DBG_IR_W-1:0] ir_sr;

	always_comb begin
		case (state)
			jtag_pkg::TEST_LOGIC_RESET: state_nxt = tms_i ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::RUN_TEST_IDLE:    state_nxt = tms_i ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_DR_SCAN:   state_nxt = tms_i ? jtag_pkg::SELECT_IR_SCAN : jtag_pkg::CAPTURE_DR;
			jtag_pkg::CAPTURE_DR:       state_nxt = tms_i ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SHIFT_DR:         state_nxt = tms_i ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::EXIT1_DR:         state_nxt = tms_i ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::PAUSE_DR:         state_nxt = tms_i ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::EXIT2_DR:         state_nxt = tms_i ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::UPDATE_DR:        state_nxt = tms_i ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_IR_SCAN:   state_nxt = tms_i ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
			jtag_pkg::CAPTURE_IR:       state_nxt = tms_i ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::SHIFT_IR:         state_nxt = tms_i ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::EXIT1_IR:         state_nxt = tms_i ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::PAUSE_IR:         state_nxt = tms_i ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::EXIT2_IR:         state_nxt = tms_i ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
			default:                    state_nxt = tms_i ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || !trst_n_i) begin
			state <= jtag_pkg::TEST_LOGIC_RESET;
			instr_o <= jtag_pkg::IDCODE;
		end else begin
			if (tck_rise_i)
				state <= state_nxt;
			if (state == jtag_pkg::TEST_LOGIC_RESET) begin
				instr_o <= jtag_pkg::IDCODE;
			end else if (tck_rise_i && state_nxt == jtag_pkg::UPDATE_IR) begin
				case (ir_sr)
					jtag_pkg::IDCODE, jtag_pkg::CONFIG, jtag_pkg::STATUS,
					jtag_pkg::SRAM_ADDR, jtag_pkg::SRAM_DATA:
						instr_o <= jtag_pkg::jtag_instr_t'(ir_sr);
					default:
						instr_o <= jtag_pkg::BYPASS;
				endcase
			end
		end
	end

	// IR capture pattern ends in 01
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (state == jtag_pkg::CAPTURE_IR)
				ir_sr <= `DBG_IR_W'(1);
			else if (state == jtag_pkg::SHIFT_IR)
				ir_sr <= {tdi_i, ir_sr[`DBG_IR_W-1:1]};
		end
	end

	// TDO moves on the falling edge so it is stable at the next rise
	always_ff @(posedge clk) begin
		if (!rst_n_i || !trst_n_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			if (state == jtag_pkg::SHIFT_IR)
				tdo_o <= ir_sr[0];
			else if (state == jtag_pkg::SHIFT_DR)
				tdo_o <= dr_tdo_i;
			else
				tdo_o <= 1'b0;
		end
	end

	// Levels, qualified by tck_rise in the data registers
	assign capture_dr_o = (state == jtag_pkg::CAPTURE_DR);
	assign shift_dr_o = (state == jtag_pkg::SHIFT_DR);
	assign update_dr_o = (state_nxt == jtag_pkg::UPDATE_DR);
endmodule

`default_nettype wire

/* include/dbg_macros.svh */
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// Instruction register
`define DBG_IR_W 4

// Loop estimates
`define DBG_PH_W 16
`define DBG_FR_W 16

// Phase detector sample, signed
`define DBG_PD_W 8

// Gains are right-shift counts
`define DBG_K_W 4
`define DBG_PI_W 8

// Capture memory depth is 2**DBG_ADDR_W
`define DBG_ADDR_W 6

`define DBG_IDCODE 32'h1cd0_5a01

`endif
